// File: compile.f
design/ciPkg.sv
design/profilePkg.sv
design/profCmdIf.sv
design/profileCommandDecoder.sv
design/profileCounter.sv
design/profileReadout.sv
design/profilerTop.sv
verification/profilerTb.sv

// File: run.sh
#!/bin/sh
# Build and run the profiler testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f compile.f --top-module profilerTb \
  -Mdir obj_dir -o profilerSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

output=$(./obj_dir/profilerSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "SIMULATION PASSED"; then
  exit 0
fi
exit 1

// File: verification/profilerTb.sv
`timescale 1ns/1ps

module profilerTb;
  import ciPkg::*;
  import profilePkg::*;

  localparam ciId_t customId      = 8'd12;
  localparam int    counterWidth  = 32;
  localparam int    clkPeriod     = 100;
  localparam int    resetCycles   = 5;
  localparam int    issueCycles   = 2;  // Strobe cycle plus one idle cycle.
  localparam int    numIssues     = 24;
  localparam int    waitCycles    = 17;
  localparam int    eventCycles   = 40;
  localparam int    freezeCycles  = 10;
  localparam int    settleCycles  = 30;
  localparam int    marginCycles  = 50;
  localparam int    timeoutCycles = resetCycles + numIssues * issueCycles + waitCycles +
                                    eventCycles + freezeCycles + settleCycles + marginCycles;

  logic    systemClock;
  logic    arstN;
  logic    ciStart;
  ciId_t   ciN;
  ciData_t ciDataA;
  ciData_t ciDataB;
  logic    stall;
  logic    busIdle;
  logic    ciDone;
  ciData_t ciResult;

  logic [counterWidth-1:0] modelCount [numCounters];
  logic [numCounters-1:0]  modelEn;
  logic [numCounters-1:0]  modelEvent;
  logic                    expDone;
  ciData_t                 expResult;

  int errorCount = 0;
  int doneCount  = 0;
  int testCount  = 0;
  int failCount  = 0;

  profilerTop #(
    .customId(customId),
    .counterWidth(counterWidth)
  ) i_dut (
    .systemClock(systemClock),
    .arstN(arstN),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .ciDone(ciDone),
    .ciResult(ciResult),
    .stall(stall),
    .busIdle(busIdle)
  );

  initial begin
    systemClock = 1'b0;
    forever #(clkPeriod / 2) systemClock = ~systemClock;
  end

  // ====================
  // Random event levels
  // ====================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin : eventDriver
    logic [31:0] rngState;
    rngState = 32'd75;
    stall    = 1'b0;
    busIdle  = 1'b0;
    forever begin
      @(posedge systemClock);
      rngState = xorshift32(rngState);
      stall   <= rngState[3];
      busIdle <= rngState[11];
    end
  end

  // ====================
  // Reference model
  // ====================

  assign modelEvent = {busIdle, stall, 1'b1}; // Bus idle, stall, cycle.
  assign expDone    = ciStart && (ciN == customId);

  always_comb begin
    expResult = '0;
    if (expDone && ciDataA[1:0] != 2'd3) begin
      expResult = ciData_t'(modelCount[ciDataA[1:0]]);
    end
  end

  always @(posedge systemClock or negedge arstN) begin
    if (!arstN) begin
      modelEn <= '0;
      for (int i = 0; i < numCounters; i++) begin
        modelCount[i] <= '0;
      end
    end else begin
      for (int i = 0; i < numCounters; i++) begin
        if (expDone && ciDataB[clearLsb + i]) begin
          modelCount[i] <= '0;
        end else if (modelEn[i] && modelEvent[i]) begin
          modelCount[i] <= modelCount[i] + 1;
        end
        if (expDone && ciDataB[disableLsb + i]) begin
          modelEn[i] <= 1'b0;
        end else if (expDone && ciDataB[enableLsb + i]) begin
          modelEn[i] <= 1'b1;
        end
      end
    end
  end

  always @(posedge systemClock) begin
    if (arstN && ciDone) begin
      doneCount <= doneCount + 1;
    end
  end

  // ====================
  // Checks
  // ====================

  doneCheck: assert property (@(posedge systemClock) disable iff (!arstN) ciDone == expDone)
    else begin
      errorCount++;
      $display("ERROR t=%0t ciDone got %b expected %b", $time, $sampled(ciDone),
               $sampled(expDone));
    end

  resultCheck: assert property (@(posedge systemClock) disable iff (!arstN)
                                ciResult == expResult)
    else begin
      errorCount++;
      $display("ERROR t=%0t ciResult got %h expected %h", $time, $sampled(ciResult),
               $sampled(expResult));
    end

  // ====================
  // Stimulus helpers
  // ====================

  function automatic ciData_t controlWord(input logic [2:0] en, input logic [2:0] dis,
                                          input logic [2:0] clr);
    ciData_t w;
    w = '0;
    w[enableLsb +: numCounters]  = en;
    w[disableLsb +: numCounters] = dis;
    w[clearLsb +: numCounters]   = clr;
    return w;
  endfunction

  task automatic issueCommand(input ciId_t id, input ciData_t dataA, input ciData_t dataB);
    @(posedge systemClock);
    ciStart <= 1'b1;
    ciN     <= id;
    ciDataA <= dataA;
    ciDataB <= dataB;
    @(posedge systemClock);
    ciStart <= 1'b0;
    ciN     <= '0;
    ciDataA <= '0;
    ciDataB <= '0;
  endtask

  task automatic readCounter(input logic [1:0] sel);
    issueCommand(customId, ciData_t'(sel), '0);
  endtask

  task automatic idleCycles(input int n);
    repeat (n) @(posedge systemClock);
  endtask

  task automatic reportTest(input string name, input int errorsBefore, input int donesBefore);
    testCount++;
    if (errorCount > errorsBefore) begin
      failCount++;
    end
    $display("Test %0d %s: %0d done pulses, %0d mismatches", testCount, name,
             doneCount - donesBefore, errorCount - errorsBefore);
  endtask

  // ====================
  // Tests
  // ====================

  initial begin : mainFlow
    int errs;
    int dones;
    arstN   = 1'b0;
    ciStart = 1'b0;
    ciN     = '0;
    ciDataA = '0;
    ciDataB = '0;
    repeat (resetCycles) @(posedge systemClock);
    arstN <= 1'b1;

    errs = errorCount;
    dones = doneCount;
    for (int i = 0; i < numCounters; i++) begin
      readCounter(2'(i));
    end
    idleCycles(2);
    reportTest("reset reads", errs, dones);

    errs = errorCount;
    dones = doneCount;
    issueCommand(customId, '0, controlWord(3'b001, 3'b000, 3'b000));
    idleCycles(waitCycles);
    readCounter(cycleCounter);
    idleCycles(5);
    readCounter(cycleCounter);
    reportTest("cycle count", errs, dones);

    errs = errorCount;
    dones = doneCount;
    issueCommand(customId, '0, controlWord(3'b110, 3'b000, 3'b110));
    idleCycles(eventCycles);
    readCounter(stallCounter);
    readCounter(busIdleCounter);
    reportTest("event counts", errs, dones);

    errs = errorCount;
    dones = doneCount;
    issueCommand(customId, '0, controlWord(3'b000, 3'b010, 3'b000)); // Freeze stall.
    idleCycles(freezeCycles);
    readCounter(stallCounter);
    readCounter(stallCounter);
    issueCommand(customId, '0, controlWord(3'b000, 3'b000, 3'b010));
    readCounter(stallCounter);
    issueCommand(customId, '0, controlWord(3'b100, 3'b000, 3'b100)); // Restart bus idle.
    idleCycles(6);
    readCounter(busIdleCounter);
    issueCommand(customId, '0, controlWord(3'b001, 3'b001, 3'b000));
    idleCycles(5);
    readCounter(cycleCounter);
    readCounter(cycleCounter);
    reportTest("control rules", errs, dones);

    errs = errorCount;
    dones = doneCount;
    issueCommand(customId + 8'd1, '0, controlWord(3'b111, 3'b000, 3'b111));
    readCounter(cycleCounter);
    readCounter(stallCounter);
    readCounter(busIdleCounter);
    readCounter(2'd3);
    idleCycles(2);
    reportTest("foreign id and bad index", errs, dones);

    $display("Tests: %0d run, %0d failed, %0d mismatches, %0d done pulses", testCount,
             failCount, errorCount, doneCount);
    if (errorCount == 0 && failCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(timeoutCycles * clkPeriod);
    $display("Watchdog expired after %0d cycles, the tests did not finish.", timeoutCycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: design/profilerTop.sv
`timescale 1ns/1ps

module profilerTop #(
  parameter ciPkg::ciId_t customId     = 8'd12,
  parameter int unsigned  counterWidth = profilePkg::defaultCounterWidth
) (
  input  logic           systemClock,
  input  logic           arstN,

  // Custom-instruction side.
  input  logic           ciStart,
  input  ciPkg::ciId_t   ciN,
  input  ciPkg::ciData_t ciDataA,
  input  ciPkg::ciData_t ciDataB,
  output logic           ciDone,
  output ciPkg::ciData_t ciResult,

  // Event levels sampled every cycle.
  input  logic           stall,
  input  logic           busIdle
);
  import ciPkg::*;
  import profilePkg::*;

  counterMask_t            eventLevels;
  logic [counterWidth-1:0] counts [numCounters];

  if (counterWidth < 1 || counterWidth > ciDataWidth) begin : genWidthCheck
    $error("counterWidth must lie between 1 and the data width.");
  end

  profCmdIf cmd ();

  // ====================
  // Command decode
  // ====================

  profileCommandDecoder #(
    .customId(customId)
  ) decoder (
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .cmd(cmd.decoder)
  );

  // ====================
  // Counters
  // ====================

  always_comb begin
    eventLevels                 = '0;
    eventLevels[cycleCounter]   = 1'b1; // Every cycle counts.
    eventLevels[stallCounter]   = stall;
    eventLevels[busIdleCounter] = busIdle;
  end

  for (genvar i = 0; i < numCounters; i++) begin : genCounter
    profileCounter #(
      .counterIndex(i),
      .counterWidth(counterWidth)
    ) counter (
      .systemClock(systemClock),
      .arstN(arstN),
      .cmd(cmd.counter),
      .countEvent(eventLevels[i]),
      .count(counts[i])
    );
  end

  // ====================
  // Readout
  // ====================

  profileReadout #(
    .counterWidth(counterWidth)
  ) readout (
    .cmd(cmd.readout),
    .counts(counts),
    .ciDone(ciDone),
    .ciResult(ciResult)
  );

endmodule

// File: design/profileReadout.sv
`timescale 1ns/1ps

module profileReadout #(
  parameter int unsigned counterWidth = profilePkg::defaultCounterWidth
) (
  profCmdIf.readout               cmd,
  input  logic [counterWidth-1:0] counts [profilePkg::numCounters],
  output logic                    ciDone,
  output ciPkg::ciData_t          ciResult
);
  import ciPkg::*;
  import profilePkg::*;

  ciData_t selected;

  // ====================
  // Counter select
  // ====================

  // Index 3 matches no counter and leaves the word at zero.
  always_comb begin
    selected = '0;
    for (int i = 0; i < numCounters; i++) begin
      if (cmd.counterSel == counterSel_t'(i)) begin
        selected = ciData_t'(counts[i]);
      end
    end
  end

  // ====================
  // Result gating
  // ====================

  // Idle cycles return zero so results of several units can be OR-ed.
  assign ciDone   = cmd.hit;
  assign ciResult = cmd.hit ? selected : '0;

endmodule

// File: design/profileCounter.sv
`timescale 1ns/1ps

module profileCounter #(
  parameter int unsigned counterIndex = 0,
  parameter int unsigned counterWidth = profilePkg::defaultCounterWidth
) (
  input  logic                    systemClock,
  input  logic                    arstN,
  profCmdIf.counter               cmd,
  input  logic                    countEvent,  // Event level for this counter.
  output logic [counterWidth-1:0] count
);
  import profilePkg::*;

  logic enabled;
  logic clearNow;

  if (counterIndex >= numCounters) begin : genIndexCheck
    $error("Counter index outside the mask width.");
  end

  assign clearNow = cmd.hit && cmd.clearMask[counterIndex];

  // ====================
  // Enable flag
  // ====================

  always_ff @(posedge systemClock or negedge arstN) begin
    if (!arstN) begin
      enabled <= 1'b0;
    end else if (cmd.hit) begin
      if (cmd.disableMask[counterIndex]) begin
        enabled <= 1'b0; // Disable wins.
      end else if (cmd.enableMask[counterIndex]) begin
        enabled <= 1'b1;
      end
    end
  end

  // ====================
  // Event count
  // ====================

  always_ff @(posedge systemClock or negedge arstN) begin
    if (!arstN) begin
      count <= '0;
    end else if (clearNow) begin
      count <= '0;
    end else if (enabled && countEvent) begin
      count <= count + 1'b1; // Wraps at counterWidth bits.
    end
  end

  // A stopped counter holds its value across any number of events.
  assert property (@(posedge systemClock) disable iff (!arstN)
                   !enabled && !clearNow |=> $stable(count))
    else $error("Counter %0d moved while disabled.", counterIndex);

  assert property (@(posedge systemClock) disable iff (!arstN)
                   clearNow |=> count == '0)
    else $error("Counter %0d not zero after clear.", counterIndex);

endmodule

// File: design/profileCommandDecoder.sv
`timescale 1ns/1ps

module profileCommandDecoder #(
  parameter ciPkg::ciId_t customId = 8'd12
) (
  input  logic           ciStart,
  input  ciPkg::ciId_t   ciN,
  input  ciPkg::ciData_t ciDataA,
  input  ciPkg::ciData_t ciDataB,
  profCmdIf.decoder      cmd
);
  import ciPkg::*;
  import profilePkg::*;

  logic match;

  // ====================
  // Control word layout
  // ====================

  // The three mask fields must not overlap and must fit in operand B.
  if ((disableLsb < enableLsb + numCounters) || (clearLsb < disableLsb + numCounters) ||
      (clearLsb + numCounters > ciDataWidth)) begin : genLayoutCheck
    $error("Profiler mask fields overlap or exceed the operand width.");
  end

  // ====================
  // Instruction match
  // ====================

  assign match   = ciStart && (ciN == customId);
  assign cmd.hit = match;

  assign cmd.counterSel = ciDataA[$bits(counterSel_t)-1:0]; // Low bits of operand A.

  // Masks are quiet unless this instruction is issued.
  assign cmd.enableMask  = match ? ciDataB[enableLsb +: numCounters]  : '0;
  assign cmd.disableMask = match ? ciDataB[disableLsb +: numCounters] : '0;
  assign cmd.clearMask   = match ? ciDataB[clearLsb +: numCounters]   : '0;

endmodule

// File: design/profCmdIf.sv
`timescale 1ns/1ps

interface profCmdIf;
  import profilePkg::*;

  logic         hit;         // Pulse of a matching instruction.
  counterSel_t  counterSel;  // Counter to read back.
  counterMask_t enableMask;
  counterMask_t disableMask;
  counterMask_t clearMask;

  modport decoder (
    output hit,
    output counterSel,
    output enableMask,
    output disableMask,
    output clearMask
  );

  // Counters only care about the masks.
  modport counter (
    input hit,
    input enableMask,
    input disableMask,
    input clearMask
  );

  modport readout (
    input hit,
    input counterSel
  );

endinterface

// File: design/profilePkg.sv
package profilePkg;

  // ====================
  // Counter set
  // ====================

  localparam int unsigned numCounters = 3;

  typedef logic [numCounters-1:0] counterMask_t; // One bit per counter.
  typedef logic [1:0]             counterSel_t;  // Index taken from operand A.

  // Fixed roles of the counters.
  localparam counterSel_t cycleCounter   = 2'd0;
  localparam counterSel_t stallCounter   = 2'd1;
  localparam counterSel_t busIdleCounter = 2'd2;

  // ====================
  // Counter geometry
  // ====================

  localparam int unsigned defaultCounterWidth = 32;

endpackage

// File: design/ciPkg.sv
package ciPkg;

  // ====================
  // Custom-instruction port widths
  // ====================

  localparam int unsigned ciIdWidth   = 8;  // Instruction number.
  localparam int unsigned ciDataWidth = 32; // Operands and result.

  typedef logic [ciIdWidth-1:0]   ciId_t;
  typedef logic [ciDataWidth-1:0] ciData_t;

  // ====================
  // Profiler control word
  // ====================

  // Operand B holds three masks with one bit per counter.
  // Each field starts at its own nibble.
  localparam int unsigned enableLsb  = 0;
  localparam int unsigned disableLsb = 4;
  localparam int unsigned clearLsb   = 8;

endpackage
